// ==== src/ntm_math_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// Arithmetic definitions for the matrix exponentiation unit
// Word type shared by operands, modulo and results
// Import inside module bodies, scoped names in port lists
//////////////////////////////////////////////////////////////////////

`default_nettype none

package ntm_math_pkg;

  // Operand, modulo and result width
  localparam int DATA_SIZE = 16;

  // Double width for products before reduction
  localparam int PROD_SIZE = 2 * DATA_SIZE;

  // Square-and-multiply scans every exponent bit
  localparam int EXP_STEPS = DATA_SIZE;
  localparam int STEP_SIZE = $clog2(EXP_STEPS);

  typedef logic [DATA_SIZE-1:0] word_t;
  typedef logic [PROD_SIZE-1:0] product_t;

endpackage

`default_nettype wire

// ==== src/ntm_shape_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// Matrix shape definitions
// Row and column indices and sizes, at most 15 per dimension
//////////////////////////////////////////////////////////////////////

`default_nettype none

package ntm_shape_pkg;

  // Width of row and column counters
  localparam int INDEX_SIZE = 4;

  // Row index, column index or matrix size
  typedef logic [INDEX_SIZE-1:0] index_t;

endpackage

`default_nettype wire

// ==== src/ntm_scalar_exponentiator.sv ====
//////////////////////////////////////////////////////////////////////
// Modular exponentiation of one base by one exponent
// Pulse exp_start with stable operands, result valid with exp_done
// One cycle base reduction, then one exponent bit per cycle, MSB first
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module ntm_scalar_exponentiator (
  input  wire                  CLK,
  input  wire                  RST,
  input  wire                  exp_start,
  input  ntm_math_pkg::word_t  base_in,
  input  ntm_math_pkg::word_t  exponent_in,
  input  ntm_math_pkg::word_t  modulo_in,
  output logic                 exp_done,
  output ntm_math_pkg::word_t  exp_result
);

  import ntm_math_pkg::*;

  //////////////////////////////////////////////////////////////////////
  // Signals
  //////////////////////////////////////////////////////////////////////

  // Control
  logic                 busy_r;
  logic [STEP_SIZE-1:0] step_r;

  // Operands held for the whole run
  word_t base_r;
  word_t exp_r;
  word_t mod_r;
  word_t acc_r;

  // One square-and-multiply step
  product_t sq_full;
  product_t mul_full;
  word_t    sq_mod;
  word_t    mul_mod;
  word_t    acc_next;

  //////////////////////////////////////////////////////////////////////
  // Step datapath
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    // Square, then reduce
    sq_full  = product_t'(acc_r) * product_t'(acc_r);
    sq_mod   = word_t'(sq_full % product_t'(mod_r));
    // Multiply by base when the current bit is set
    mul_full = product_t'(sq_mod) * product_t'(base_r);
    mul_mod  = word_t'(mul_full % product_t'(mod_r));
    acc_next = exp_r[DATA_SIZE-1] ? mul_mod : sq_mod;
  end

  // Operand and accumulator registers
  always_ff @(posedge CLK) begin
    if (exp_start) begin
      // Reduction cycle, accumulator starts at 1
      base_r <= base_in % modulo_in;
      exp_r  <= exponent_in;
      mod_r  <= modulo_in;
      acc_r  <= word_t'(1);
    end else if (busy_r) begin
      acc_r <= acc_next;
      // Next exponent bit moves to the MSB
      exp_r <= exp_r << 1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Bit counter
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      busy_r   <= 1'b0;
      step_r   <= '0;
      exp_done <= 1'b0;
    end else begin
      exp_done <= 1'b0;
      if (exp_start) begin
        busy_r <= 1'b1;
        step_r <= '0;
      end else if (busy_r) begin
        step_r <= step_r + 1'b1;
        // Last bit consumed this cycle
        if (step_r == STEP_SIZE'(EXP_STEPS - 1)) begin
          busy_r   <= 1'b0;
          exp_done <= 1'b1;
        end
      end
    end
  end

  assign exp_result = acc_r;

endmodule

`default_nettype wire

// ==== src/ntm_vector_exponentiator.sv ====
//////////////////////////////////////////////////////////////////////
// Column loop of the matrix exponentiation unit
// Pairs the A and B strobes of each element and runs the scalar unit
// vec_start opens a row, vec_ready marks its last element
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module ntm_vector_exponentiator (
  input  wire                    CLK,
  input  wire                    RST,
  input  wire                    vec_start,
  input  ntm_shape_pkg::index_t  size_in,
  input  ntm_math_pkg::word_t    modulo_in,
  input  wire                    data_a_in_enable,
  input  ntm_math_pkg::word_t    data_a_in,
  input  wire                    data_b_in_enable,
  input  ntm_math_pkg::word_t    data_b_in,
  output logic                   elem_done,
  output ntm_math_pkg::word_t    elem_out,
  output logic                   vec_ready
);

  import ntm_math_pkg::*;
  import ntm_shape_pkg::*;

  typedef enum logic [1:0] {
    st_idle,
    st_collect,
    st_compute,
    st_emit
  } state_t;

  state_t state_r;
  index_t col_r;
  logic   held_a_r;
  logic   held_b_r;
  logic   last_col;
  word_t  a_r;
  word_t  b_r;

  // Scalar unit handshake
  logic   exp_start;
  logic   exp_done;
  word_t  exp_result;

  assign last_col = (col_r == index_t'(size_in - 1'b1));

  // Operand capture, first strobe of each operand wins
  always_ff @(posedge CLK) begin
    if (state_r == st_collect && data_a_in_enable && !held_a_r)
      a_r <= data_a_in;
    if (state_r == st_collect && data_b_in_enable && !held_b_r)
      b_r <= data_b_in;
  end

  //////////////////////////////////////////////////////////////////////
  // Element FSM
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state_r   <= st_idle;
      col_r     <= '0;
      held_a_r  <= 1'b0;
      held_b_r  <= 1'b0;
      exp_start <= 1'b0;
      elem_done <= 1'b0;
      elem_out  <= '0;
      vec_ready <= 1'b0;
    end else begin
      // Pulses by default
      exp_start <= 1'b0;
      elem_done <= 1'b0;
      vec_ready <= 1'b0;
      case (state_r)
        st_idle: begin
          if (vec_start) begin
            col_r   <= '0;
            state_r <= st_collect;
          end
        end
        st_collect: begin
          if (data_a_in_enable)
            held_a_r <= 1'b1;
          if (data_b_in_enable)
            held_b_r <= 1'b1;
          // Both operands in hand, incl. strobes of this cycle
          if ((held_a_r || data_a_in_enable) && (held_b_r || data_b_in_enable)) begin
            exp_start <= 1'b1;
            state_r   <= st_compute;
          end
        end
        st_compute: begin
          if (exp_done) begin
            elem_done <= 1'b1;
            elem_out  <= exp_result;
            vec_ready <= last_col;
            held_a_r  <= 1'b0;
            held_b_r  <= 1'b0;
            state_r   <= st_emit;
          end
        end
        st_emit: begin
          if (last_col) begin
            // Next row may start straight away
            col_r   <= '0;
            state_r <= vec_start ? st_collect : st_idle;
          end else begin
            col_r   <= col_r + 1'b1;
            state_r <= st_collect;
          end
        end
        default: state_r <= st_idle;
      endcase
    end
  end

  ntm_scalar_exponentiator scalar_exponentiator_i (
    .CLK        (CLK),
    .RST        (RST),
    .exp_start  (exp_start),
    .base_in    (a_r),
    .exponent_in(b_r),
    .modulo_in  (modulo_in),
    .exp_done   (exp_done),
    .exp_result (exp_result)
  );

endmodule

`default_nettype wire

// ==== src/ntm_matrix_exponentiator.sv ====
//////////////////////////////////////////////////////////////////////
// Element-wise matrix exponentiation, C(i,j) = A(i,j)^B(i,j) mod M
// Pulse start with modulo and sizes, then stream elements row-major
// Results leave on data_out_j_enable, rows and matrix end are flagged
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module ntm_matrix_exponentiator (
  input  wire                    CLK,
  input  wire                    RST,
  input  wire                    start,
  input  ntm_math_pkg::word_t    modulo_in,
  input  ntm_shape_pkg::index_t  size_i_in,
  input  ntm_shape_pkg::index_t  size_j_in,
  input  wire                    data_a_in_enable,
  input  ntm_math_pkg::word_t    data_a_in,
  input  wire                    data_b_in_enable,
  input  ntm_math_pkg::word_t    data_b_in,
  output logic                   ready,
  output logic                   data_out_i_enable,
  output logic                   data_out_j_enable,
  output ntm_math_pkg::word_t    data_out
);

  import ntm_math_pkg::*;
  import ntm_shape_pkg::*;

  //////////////////////////////////////////////////////////////////////
  // Signals
  //////////////////////////////////////////////////////////////////////

  // Matrix parameters held from start
  word_t  modulo_r;
  index_t size_i_r;
  index_t size_j_r;

  // Row loop
  logic   running_r;
  index_t row_r;
  logic   row_start_r;
  logic   last_row;

  // Vector unit
  logic   vec_start;
  logic   vec_ready;
  logic   elem_done;
  word_t  elem_out;

  //////////////////////////////////////////////////////////////////////
  // Row loop
  //////////////////////////////////////////////////////////////////////

  assign last_row = (row_r == index_t'(size_i_r - 1'b1));

  // Matrix parameters, loaded only on an accepted start
  always_ff @(posedge CLK) begin
    if (start && !running_r) begin
      modulo_r <= modulo_in;
      size_i_r <= size_i_in;
      size_j_r <= size_j_in;
    end
  end

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      running_r   <= 1'b0;
      row_r       <= '0;
      row_start_r <= 1'b0;
    end else begin
      row_start_r <= 1'b0;
      if (!running_r) begin
        if (start) begin
          // Row 0 opens the cycle after start
          running_r   <= 1'b1;
          row_r       <= '0;
          row_start_r <= 1'b1;
        end
      end else if (vec_ready) begin
        if (last_row) begin
          running_r <= 1'b0;
        end else begin
          row_r <= row_r + 1'b1;
        end
      end
    end
  end

  // Next row restarts in the cycle of the row end, no gap for the host
  assign vec_start = row_start_r | (vec_ready & ~last_row);

  //////////////////////////////////////////////////////////////////////
  // Outputs
  //////////////////////////////////////////////////////////////////////

  assign data_out_j_enable = elem_done;
  assign data_out          = elem_out;
  assign data_out_i_enable = vec_ready;
  // Last element of last row
  assign ready             = vec_ready & last_row;

  ntm_vector_exponentiator vector_exponentiator_i (
    .CLK             (CLK),
    .RST             (RST),
    .vec_start       (vec_start),
    .size_in         (size_j_r),
    .modulo_in       (modulo_r),
    .data_a_in_enable(data_a_in_enable),
    .data_a_in       (data_a_in),
    .data_b_in_enable(data_b_in_enable),
    .data_b_in       (data_b_in),
    .elem_done       (elem_done),
    .elem_out        (elem_out),
    .vec_ready       (vec_ready)
  );

endmodule

`default_nettype wire

// ==== tests/ntm_matrix_exponentiator_props.sv ====
//////////////////////////////////////////////////////////////////////
// Concurrent assertions on the matrix exponentiation outputs
// Bound to the top level from the testbench
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module ntm_matrix_exponentiator_props (
  input  wire                  CLK,
  input  wire                  RST,
  input  wire                  ready,
  input  wire                  data_out_i_enable,
  input  wire                  data_out_j_enable,
  input  ntm_math_pkg::word_t  data_out
);

  // Matrix end comes with row end and element strobe
  a_ready_framed: assert property (@(posedge CLK) disable iff (RST)
    ready |-> (data_out_i_enable && data_out_j_enable))
    else $error("ready raised without row end and element strobe");

  // Row end comes with an element strobe
  a_row_framed: assert property (@(posedge CLK) disable iff (RST)
    data_out_i_enable |-> data_out_j_enable)
    else $error("data_out_i_enable raised without data_out_j_enable");

  // All three are single-cycle pulses
  a_pulse_width: assert property (@(posedge CLK) disable iff (RST)
    (ready || data_out_i_enable || data_out_j_enable) |=>
      !(ready || data_out_i_enable || data_out_j_enable))
    else $error("output pulse held longer than one cycle");

  // Known outputs once out of reset
  a_no_unknown: assert property (@(posedge CLK) disable iff (RST)
    !$isunknown({ready, data_out_i_enable, data_out_j_enable, data_out}))
    else $error("unknown value on an output after reset");

endmodule

`default_nettype wire

// ==== tests/ntm_matrix_exponentiator_tb.sv ====
//////////////////////////////////////////////////////////////////////
// Testbench for the matrix exponentiation unit
// Streams random matrices from a fixed seed, checks each result
// against a square-and-multiply model, row and matrix framing
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module ntm_matrix_exponentiator_tb;

  import ntm_math_pkg::*;
  import ntm_shape_pkg::*;

  // Matrix kinds
  localparam int MODE_EDGE    = 0;
  localparam int MODE_ORDER   = 1;
  localparam int MODE_IGNORED = 2;
  localparam int MODE_RANDOM  = 3;
  localparam int NUM_MATRICES = 14;

  logic   CLK;
  logic   RST;
  logic   start;
  word_t  modulo_in;
  index_t size_i_in;
  index_t size_j_in;
  logic   data_a_in_enable;
  word_t  data_a_in;
  logic   data_b_in_enable;
  word_t  data_b_in;
  logic   ready;
  logic   data_out_i_enable;
  logic   data_out_j_enable;
  word_t  data_out;

  integer seed;
  int     errors = 0;
  int     cycle_count = 0;
  int     cycle_limit = 0;
  int     expected_outputs = 0;
  int     seen_outputs = 0;
  int     rows_q [NUM_MATRICES];
  int     cols_q [NUM_MATRICES];
  int     mode_q [NUM_MATRICES];

  ntm_matrix_exponentiator ntm_matrix_exponentiator_i (
    .CLK              (CLK),
    .RST              (RST),
    .start            (start),
    .modulo_in        (modulo_in),
    .size_i_in        (size_i_in),
    .size_j_in        (size_j_in),
    .data_a_in_enable (data_a_in_enable),
    .data_a_in        (data_a_in),
    .data_b_in_enable (data_b_in_enable),
    .data_b_in        (data_b_in),
    .ready            (ready),
    .data_out_i_enable(data_out_i_enable),
    .data_out_j_enable(data_out_j_enable),
    .data_out         (data_out)
  );

  bind ntm_matrix_exponentiator ntm_matrix_exponentiator_props props_i (
    .CLK              (CLK),
    .RST              (RST),
    .ready            (ready),
    .data_out_i_enable(data_out_i_enable),
    .data_out_j_enable(data_out_j_enable),
    .data_out         (data_out)
  );

  // 4 ns clock
  initial begin
    CLK = 1'b0;
    forever #2 CLK = ~CLK;
  end

  // Run limit and output count
  always @(posedge CLK) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count > cycle_limit) begin
      $display("Timeout after %0d cycles, the DUT stopped producing results", cycle_count);
      $display("CHECKS FAILED");
      $fatal(1, "Simulation timeout");
    end
  end

  always @(negedge CLK) begin
    if (!RST && data_out_j_enable)
      seen_outputs <= seen_outputs + 1;
  end

  //////////////////////////////////////////////////////////////////////
  // Model and helpers
  //////////////////////////////////////////////////////////////////////

  function automatic int rand_below(input int n);
    int r;
    r = $random(seed) & 32'h7fffffff;
    return r % n;
  endfunction

  // Small moduli half of the time, to hit many wrap-arounds
  function automatic word_t pick_modulo();
    if (rand_below(2) == 0)
      return word_t'(2 + rand_below(30));
    return word_t'(2 + rand_below(65534));
  endfunction

  // LSB-first repeated squaring
  function automatic word_t mod_pow(input word_t a, input word_t b, input word_t m);
    longint unsigned acc;
    longint unsigned base;
    longint unsigned md;
    longint unsigned e;
    md   = 64'(m);
    base = 64'(a) % md;
    acc  = 64'd1 % md;
    e    = 64'(b);
    while (e != 64'd0) begin
      if (e[0])
        acc = (acc * base) % md;
      base = (base * base) % md;
      e    = e >> 1;
    end
    return word_t'(acc);
  endfunction

  task automatic check_word(input string name, input word_t expected, input word_t actual);
    if (actual !== expected) begin
      errors++;
      $display("ERROR %s: expected %0d, actual %0d", name, expected, actual);
      $display("CHECKS FAILED");
      $fatal(1, "Result mismatch");
    end
  endtask

  task automatic check_flag(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      errors++;
      $display("ERROR %s: expected %0b, actual %0b", name, expected, actual);
      $display("CHECKS FAILED");
      $fatal(1, "Flag mismatch");
    end
  endtask

  // One-cycle strobe on either or both operands
  task automatic strobe_operands(input logic en_a, input word_t a, input logic en_b,
                                 input word_t b);
    @(posedge CLK);
    data_a_in_enable <= en_a;
    data_a_in        <= a;
    data_b_in_enable <= en_b;
    data_b_in        <= b;
    @(posedge CLK);
    data_a_in_enable <= 1'b0;
    data_b_in_enable <= 1'b0;
  endtask

  // Order 0 A first, 1 B first, 2 same cycle
  task automatic send_element(input word_t a, input word_t b, input int order,
                              input bit spurious);
    repeat (rand_below(2)) @(posedge CLK);
    if (order == 2) begin
      strobe_operands(1'b1, a, 1'b1, b);
    end else if (order == 0) begin
      strobe_operands(1'b1, a, 1'b0, word_t'($random(seed)));
      repeat (rand_below(2)) @(posedge CLK);
      strobe_operands(1'b0, word_t'($random(seed)), 1'b1, b);
    end else begin
      strobe_operands(1'b0, word_t'($random(seed)), 1'b1, b);
      repeat (rand_below(2)) @(posedge CLK);
      strobe_operands(1'b1, a, 1'b0, word_t'($random(seed)));
    end
    // Garbage operands while the element computes
    if (spurious) begin
      repeat (rand_below(3)) @(posedge CLK);
      strobe_operands(1'b1, word_t'($random(seed)), 1'b1, word_t'($random(seed)));
    end
  endtask

  task automatic wait_result();
    do begin
      @(negedge CLK);
    end while (!data_out_j_enable);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Matrix runs
  //////////////////////////////////////////////////////////////////////

  task automatic run_matrix(input int idx);
    string name;
    string elem_name;
    int    order;
    bit    spurious;
    word_t m;
    word_t a;
    word_t b;
    word_t a_fix;
    word_t b_fix;
    word_t expected;
    m     = pick_modulo();
    a_fix = word_t'($random(seed));
    b_fix = word_t'($random(seed));
    name  = $sformatf("m%0d", idx);
    @(posedge CLK);
    start     <= 1'b1;
    modulo_in <= m;
    size_i_in <= index_t'(rows_q[idx]);
    size_j_in <= index_t'(cols_q[idx]);
    @(posedge CLK);
    // Shape must come from the start cycle only
    start     <= 1'b0;
    modulo_in <= word_t'($random(seed));
    size_i_in <= index_t'($random(seed));
    size_j_in <= index_t'($random(seed));
    for (int r = 0; r < rows_q[idx]; r++) begin
      for (int c = 0; c < cols_q[idx]; c++) begin
        a         = word_t'($random(seed));
        b         = word_t'($random(seed));
        order     = rand_below(3);
        spurious  = (rand_below(4) == 0);
        expected  = mod_pow(a, b, m);
        elem_name = $sformatf("%s[%0d][%0d]", name, r, c);
        case (mode_q[idx])
          MODE_EDGE: begin
            // Rule-based results, one edge case per column
            if (c == 0) begin
              b         = '0;
              expected  = word_t'(1) % m;
              elem_name = {name, "_exp_zero"};
            end else if (c == 1) begin
              b         = word_t'(1);
              expected  = a % m;
              elem_name = {name, "_exp_one"};
            end else begin
              a         = '0;
              b         = (b == '0) ? word_t'(1) : b;
              expected  = '0;
              elem_name = {name, "_base_zero"};
            end
          end
          MODE_ORDER: begin
            // Same operands, each strobe order once
            a        = a_fix;
            b        = b_fix;
            order    = c;
            expected = mod_pow(a, b, m);
          end
          MODE_IGNORED: spurious = 1'b1;
          default: ;
        endcase
        send_element(a, b, order, spurious);
        wait_result();
        check_word(elem_name, expected, data_out);
        check_flag({elem_name, "_row_end"}, c == cols_q[idx] - 1, data_out_i_enable);
        check_flag({elem_name, "_matrix_end"},
                   (r == rows_q[idx] - 1) && (c == cols_q[idx] - 1), ready);
        expected_outputs++;
      end
    end
  endtask

  // Shapes, including 1x1 and 4x4, returns element count
  function automatic int plan_matrices();
    int total;
    total = 0;
    for (int i = 0; i < NUM_MATRICES; i++) begin
      mode_q[i] = (i < MODE_RANDOM) ? i : MODE_RANDOM;
      rows_q[i] = 1 + rand_below(4);
      cols_q[i] = 1 + rand_below(4);
      if (i == MODE_EDGE || i == MODE_ORDER) begin
        rows_q[i] = 1;
        cols_q[i] = 3;
      end else if (i == 3) begin
        rows_q[i] = 1;
        cols_q[i] = 1;
      end else if (i == 4) begin
        rows_q[i] = 4;
        cols_q[i] = 4;
      end
      total += rows_q[i] * cols_q[i];
    end
    return total;
  endfunction

  initial begin
    int total;
    seed             = 88832;
    RST              <= 1'b1;
    start            <= 1'b0;
    modulo_in        <= '0;
    size_i_in        <= '0;
    size_j_in        <= '0;
    data_a_in_enable <= 1'b0;
    data_a_in        <= '0;
    data_b_in_enable <= 1'b0;
    data_b_in        <= '0;
    total            = plan_matrices();
    cycle_limit      = total * (EXP_STEPS + 10) + 200;
    repeat (3) @(posedge CLK);
    RST <= 1'b0;
    // Back to back, each start right after the previous ready
    for (int i = 0; i < NUM_MATRICES; i++)
      run_matrix(i);
    repeat (30) @(negedge CLK);
    check_word("output_count", word_t'(expected_outputs), word_t'(seen_outputs));
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
      $finish;
    end else begin
      $display("CHECKS FAILED");
      $fatal(1, "Testbench reported errors");
    end
  end

endmodule

`default_nettype wire

// ==== files.f ====
src/ntm_math_pkg.sv
src/ntm_shape_pkg.sv
src/ntm_scalar_exponentiator.sv
src/ntm_vector_exponentiator.sv
src/ntm_matrix_exponentiator.sv
tests/ntm_matrix_exponentiator_props.sv
tests/ntm_matrix_exponentiator_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the matrix exponentiation testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -f files.f \
  --top-module ntm_matrix_exponentiator_tb -o ntm_sim

# Pass or fail comes from the log, not the exit status
./obj_dir/ntm_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "^ALL CHECKS PASSED$" sim.log; then
  exit 0
else
  exit 1
fi
